/* hdl/gat_pkg.sv */
`default_nettype none

package gat_pkg;

  // Layer sizes
  localparam int NUM_FEAT_IN  = 16;
  localparam int NUM_FEAT_OUT = 4;
  localparam int DATA_W       = 8;
  localparam int COL_IDX_W    = $clog2(NUM_FEAT_IN);
  localparam int FO_IDX_W     = $clog2(NUM_FEAT_OUT);
  localparam int PROD_W       = 2 * DATA_W;
  localparam int WH_W         = 20;
  localparam int SCORE_W      = 32;
  localparam int NODE_ID_W    = 8;

  // APB register map, byte addresses
  localparam int APB_ADDR_W   = 12;
  localparam int APB_DATA_W   = 32;
  localparam int W_BASE       = 0;
  localparam int W_WORDS      = NUM_FEAT_IN * NUM_FEAT_OUT;
  localparam int A_BASE       = 256;
  localparam int A_LEN        = 2 * NUM_FEAT_OUT;
  localparam int A_IDX_W      = $clog2(A_LEN);

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [WH_W-1:0]    wh_t;
  typedef logic signed [SCORE_W-1:0] score_t;

  typedef struct packed {
    data_t                val;
    logic [COL_IDX_W-1:0] col;
    logic                 last;
  } h_entry_t;

  // One row of W, indexed by output feature
  typedef data_t [NUM_FEAT_OUT-1:0] wgt_row_t;
  typedef wgt_row_t [NUM_FEAT_IN-1:0] wgt_mat_t;

  // Self half in 0..3, neighbour half in 4..7
  typedef data_t [A_LEN-1:0] attn_vec_t;

  typedef struct packed {
    data_t val;
    data_t wgt;
    logic  last;
  } lane_beat_t;

  typedef wh_t [NUM_FEAT_OUT-1:0] wh_row_t;

  typedef struct packed {
    logic [NODE_ID_W-1:0] node_id;
    wh_row_t              wh;
    score_t               score_self;
    score_t               score_neigh;
  } node_result_t;

  typedef enum logic {
    FD_IDLE,
    FD_ROW
  } feeder_state_e;

endpackage

`default_nettype wire

/* hdl/gat_cfg_apb.sv */
`timescale 1ns/1ns
`default_nettype none

module gat_cfg_apb (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire  [gat_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  wire                             psel_i,
  input  wire                             penable_i,
  input  wire                             pwrite_i,
  input  wire  [gat_pkg::APB_DATA_W-1:0]  pwdata_i,
  output logic [gat_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  output gat_pkg::wgt_mat_t               wgt_o,
  output gat_pkg::attn_vec_t              attn_o
);

  import gat_pkg::*;

  logic [APB_ADDR_W-1:0] w_off;
  logic [APB_ADDR_W-1:0] a_off;
  logic                  access;
  logic                  aligned;
  logic                  in_w;
  logic                  in_a;
  logic                  addr_ok;
  logic [COL_IDX_W-1:0]  w_row;
  logic [FO_IDX_W-1:0]   w_col;
  logic [A_IDX_W-1:0]    a_idx;

  // Offsets wrap below the base, so one compare per range is enough
  assign w_off = paddr_i - APB_ADDR_W'(W_BASE);
  assign a_off = paddr_i - APB_ADDR_W'(A_BASE);

  assign in_w    = w_off < APB_ADDR_W'(4 * W_WORDS);
  assign in_a    = a_off < APB_ADDR_W'(4 * A_LEN);
  assign aligned = paddr_i[1:0] == 2'b00;
  assign addr_ok = aligned && (in_w || in_a);
  assign access  = psel_i && penable_i;

  // W word index is row * NUM_FEAT_OUT + col
  assign w_row = w_off[2 + FO_IDX_W +: COL_IDX_W];
  assign w_col = w_off[2 +: FO_IDX_W];
  assign a_idx = a_off[2 +: A_IDX_W];

  // No wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access && !addr_ok;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_o  <= '0;
      attn_o <= '0;
    end else if (access && pwrite_i && addr_ok) begin
      if (in_w) begin
        wgt_o[w_row][w_col] <= pwdata_i[DATA_W-1:0];
      end else begin
        attn_o[a_idx] <= pwdata_i[DATA_W-1:0];
      end
    end
  end

  // Bytes read back zero-extended
  always_comb begin
    prdata_o = '0;
    if (access && addr_ok) begin
      if (in_w) begin
        prdata_o[DATA_W-1:0] = wgt_o[w_row][w_col];
      end else begin
        prdata_o[DATA_W-1:0] = attn_o[a_idx];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/spmm_row_feeder.sv */
`timescale 1ns/1ns
`default_nettype none

module spmm_row_feeder (
  input  wire                                                clk,
  input  wire                                                rst_n,
  input  wire                                                h_valid_i,
  input  wire  gat_pkg::h_entry_t                            h_entry_i,
  input  wire  gat_pkg::wgt_mat_t                            wgt_i,
  input  wire                                                pipe_en_i,
  output logic                                               h_ready_o,
  output logic                                               beat_valid_o,
  output gat_pkg::lane_beat_t [gat_pkg::NUM_FEAT_OUT-1:0]    beat_o
);

  import gat_pkg::*;

  feeder_state_e state_q;
  feeder_state_e state_d;
  logic          accept;
  logic          ent_vld_q;
  data_t         ent_val_q;
  logic          ent_last_q;
  wgt_row_t      ent_row_q;

  // Stalls only when the result register is blocked
  assign h_ready_o = pipe_en_i;
  assign accept    = h_valid_i && pipe_en_i;

  // Row open or closed
  always_comb begin
    state_d = state_q;
    case (state_q)
      FD_IDLE: begin
        if (accept && !h_entry_i.last) begin
          state_d = FD_ROW;
        end
      end
      FD_ROW: begin
        if (accept && h_entry_i.last) begin
          state_d = FD_IDLE;
        end
      end
      default: state_d = FD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= FD_IDLE;
      ent_vld_q    <= 1'b0;
      beat_valid_o <= 1'b0;
    end else if (pipe_en_i) begin
      state_q      <= state_d;
      ent_vld_q    <= accept;
      beat_valid_o <= ent_vld_q;
    end
  end

  // Accepted entry with the W row picked by its column
  always_ff @(posedge clk) begin
    if (accept) begin
      ent_val_q  <= h_entry_i.val;
      ent_last_q <= h_entry_i.last;
      ent_row_q  <= wgt_i[h_entry_i.col];
    end
  end

  // Split the registered W row into one beat per lane
  always_ff @(posedge clk) begin
    if (pipe_en_i && ent_vld_q) begin
      for (int j = 0; j < NUM_FEAT_OUT; j++) begin
        beat_o[j].val  <= ent_val_q;
        beat_o[j].wgt  <= ent_row_q[j];
        beat_o[j].last <= ent_last_q;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/spmm_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module spmm_lane (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire                               beat_valid_i,
  input  wire  gat_pkg::lane_beat_t         beat_i,
  input  wire                               pipe_en_i,
  output logic                              done_o,
  output logic signed [gat_pkg::WH_W-1:0]   wh_o
);

  import gat_pkg::*;

  logic signed [PROD_W-1:0] prod_q;
  logic                     prod_vld;
  logic                     prod_last;
  wh_t                      acc_q;
  wh_t                      acc_next;

  assign acc_next = acc_q + wh_t'(prod_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_vld <= 1'b0;
      done_o   <= 1'b0;
      acc_q    <= '0;
    end else if (pipe_en_i) begin
      prod_vld <= beat_valid_i;
      done_o   <= prod_vld && prod_last;
      if (prod_vld) begin
        // Next row starts from zero
        acc_q <= prod_last ? '0 : acc_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pipe_en_i) begin
      if (beat_valid_i) begin
        prod_q    <= beat_i.val * beat_i.wgt;
        prod_last <= beat_i.last;
      end
      if (prod_vld && prod_last) begin
        wh_o <= acc_next;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/attn_score_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module attn_score_unit (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire  [gat_pkg::NUM_FEAT_OUT-1:0]    lane_done_i,
  input  wire  gat_pkg::wh_row_t              lane_wh_i,
  input  wire  gat_pkg::attn_vec_t            attn_i,
  input  wire                                 node_ready_i,
  output logic                                node_valid_o,
  output gat_pkg::node_result_t               node_result_o,
  output logic                                pipe_en_o
);

  import gat_pkg::*;

  logic [NODE_ID_W-1:0] node_cnt;
  logic                 row_done;
  logic                 held;
  score_t               self_sum;
  score_t               neigh_sum;

  // Lanes finish together
  assign row_done = &lane_done_i;

  // Result waiting on the consumer freezes the whole pipeline
  assign held      = node_valid_o && !node_ready_i;
  assign pipe_en_o = !held;

  // Both halves of a against the finished WH row
  always_comb begin
    self_sum  = '0;
    neigh_sum = '0;
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      self_sum  = self_sum + score_t'(attn_i[j]) * score_t'(lane_wh_i[j]);
      neigh_sum = neigh_sum +
                  score_t'(attn_i[j + NUM_FEAT_OUT]) * score_t'(lane_wh_i[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      node_valid_o <= 1'b0;
      node_cnt     <= '0;
    end else if (!held) begin
      node_valid_o <= row_done;
      if (row_done) begin
        // Wraps after 256 nodes
        node_cnt <= node_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!held && row_done) begin
      node_result_o.node_id     <= node_cnt;
      node_result_o.wh          <= lane_wh_i;
      node_result_o.score_self  <= self_sum;
      node_result_o.score_neigh <= neigh_sum;
    end
  end

endmodule

`default_nettype wire

/* hdl/gat_layer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module gat_layer_top (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire  [gat_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  wire                             psel_i,
  input  wire                             penable_i,
  input  wire                             pwrite_i,
  input  wire  [gat_pkg::APB_DATA_W-1:0]  pwdata_i,
  output logic [gat_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  input  wire                             h_valid_i,
  input  wire  gat_pkg::h_entry_t         h_entry_i,
  output logic                            h_ready_o,
  output logic                            node_valid_o,
  output gat_pkg::node_result_t           node_result_o,
  input  wire                             node_ready_i
);

  import gat_pkg::*;

  wgt_mat_t                      wgt;
  attn_vec_t                     attn;
  logic                          pipe_en;
  logic                          lane_beat_valid;
  lane_beat_t [NUM_FEAT_OUT-1:0] lane_beat;
  logic [NUM_FEAT_OUT-1:0]       lane_done;
  wh_row_t                       lane_wh;

  gat_cfg_apb u_cfg_apb (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .wgt_o     (wgt),
    .attn_o    (attn)
  );

  // Last entry to node_valid_o crosses feeder, two lane stages and the score register
  spmm_row_feeder u_row_feeder (
    .clk          (clk),
    .rst_n        (rst_n),
    .h_valid_i    (h_valid_i),
    .h_entry_i    (h_entry_i),
    .wgt_i        (wgt),
    .pipe_en_i    (pipe_en),
    .h_ready_o    (h_ready_o),
    .beat_valid_o (lane_beat_valid),
    .beat_o       (lane_beat)
  );

  // One lane per output feature
  for (genvar i = 0; i < NUM_FEAT_OUT; i++) begin : g_lane
    spmm_lane u_lane (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat_valid_i (lane_beat_valid),
      .beat_i       (lane_beat[i]),
      .pipe_en_i    (pipe_en),
      .done_o       (lane_done[i]),
      .wh_o         (lane_wh[i])
    );
  end

  attn_score_unit u_score (
    .clk           (clk),
    .rst_n         (rst_n),
    .lane_done_i   (lane_done),
    .lane_wh_i     (lane_wh),
    .attn_i        (attn),
    .node_ready_i  (node_ready_i),
    .node_valid_o  (node_valid_o),
    .node_result_o (node_result_o),
    .pipe_en_o     (pipe_en)
  );

endmodule

`default_nettype wire

/* dv/gat_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module gat_tb;

  import gat_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic [APB_ADDR_W-1:0] paddr_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [APB_DATA_W-1:0] pwdata_i;
  logic [APB_DATA_W-1:0] prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic                  h_valid_i;
  h_entry_t              h_entry_i;
  logic                  h_ready_o;
  logic                  node_valid_o;
  node_result_t          node_result_o;
  logic                  node_ready_i;

  int                   errors;
  int                   hold_seen;
  logic [31:0]          lfsr;
  int                   w_ref [NUM_FEAT_IN][NUM_FEAT_OUT];
  int                   a_ref [A_LEN];
  logic [NODE_ID_W-1:0] exp_id;
  h_entry_t             ent_q [$];
  node_result_t         exp_q [$];

  gat_layer_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .h_valid_i     (h_valid_i),
    .h_entry_i     (h_entry_i),
    .h_ready_o     (h_ready_o),
    .node_valid_o  (node_valid_o),
    .node_result_o (node_result_o),
    .node_ready_i  (node_ready_i)
  );

  always #10 clk = ~clk;

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int rand_byte();
    logic [7:0] b;
    b = 8'(rand_bits(8));
    return int'($signed(b));
  endfunction

  function automatic logic [APB_ADDR_W-1:0] w_addr(input int r, input int c);
    return APB_ADDR_W'(W_BASE + 4 * (r * NUM_FEAT_OUT + c));
  endfunction

  function automatic logic [APB_ADDR_W-1:0] a_addr(input int i);
    return APB_ADDR_W'(A_BASE + 4 * i);
  endfunction

  task automatic apb_check(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                           input logic [31:0] data, input logic exp_err);
    int n;
    paddr_i   = addr;
    pwrite_i  = wr;
    pwdata_i  = data;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(posedge clk);
    #2;
    penable_i = 1'b1;
    n = 0;
    #1;
    while (!pready_o && n < 50) begin
      @(posedge clk);
      #3;
      n++;
    end
    if (!pready_o) begin
      $display("Timeout at %0t waiting for pready_o", $time);
      errors++;
    end
    if (pslverr_o !== exp_err) begin
      $display("Fail t=%0t pslverr_o expected %b got %b", $time, exp_err, pslverr_o);
      errors++;
    end
    // For reads the data argument is the expected value
    if (!wr && prdata_o !== data) begin
      $display("Fail t=%0t prdata_o expected %h got %h", $time, data, prdata_o);
      errors++;
    end
    @(posedge clk);
    #2;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic load_weights();
    for (int r = 0; r < NUM_FEAT_IN; r++) begin
      for (int c = 0; c < NUM_FEAT_OUT; c++) begin
        w_ref[r][c] = rand_byte();
        apb_check(1'b1, w_addr(r, c), 32'(w_ref[r][c] & 255), 1'b0);
      end
    end
    for (int i = 0; i < A_LEN; i++) begin
      a_ref[i] = rand_byte();
      apb_check(1'b1, a_addr(i), 32'(a_ref[i] & 255), 1'b0);
    end
  endtask

  task automatic readback_all();
    for (int r = 0; r < NUM_FEAT_IN; r++) begin
      for (int c = 0; c < NUM_FEAT_OUT; c++) begin
        apb_check(1'b0, w_addr(r, c), 32'(w_ref[r][c] & 255), 1'b0);
      end
    end
    for (int i = 0; i < A_LEN; i++) begin
      apb_check(1'b0, a_addr(i), 32'(a_ref[i] & 255), 1'b0);
    end
  endtask

  // Random row with unique columns, plus its model result
  task automatic build_row();
    int           perm [NUM_FEAT_IN];
    int           wh [NUM_FEAT_OUT];
    int           len;
    int           k;
    int           tmp;
    int           v;
    int           ss;
    int           sn;
    h_entry_t     e;
    node_result_t r;
    for (int i = 0; i < NUM_FEAT_IN; i++) begin
      perm[i] = i;
    end
    for (int i = NUM_FEAT_IN - 1; i > 0; i--) begin
      k = int'(rand_bits(4)) % (i + 1);
      tmp = perm[i];
      perm[i] = perm[k];
      perm[k] = tmp;
    end
    len = int'(rand_bits(4)) + 1;
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      wh[j] = 0;
    end
    for (int i = 0; i < len; i++) begin
      v = rand_byte();
      e.val  = data_t'(v);
      e.col  = COL_IDX_W'(perm[i]);
      e.last = (i == len - 1);
      ent_q.push_back(e);
      for (int j = 0; j < NUM_FEAT_OUT; j++) begin
        wh[j] = wh[j] + v * w_ref[perm[i]][j];
      end
    end
    ss = 0;
    sn = 0;
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      ss = ss + a_ref[j] * wh[j];
      sn = sn + a_ref[j + NUM_FEAT_OUT] * wh[j];
      r.wh[j] = wh_t'(wh[j]);
    end
    r.node_id     = exp_id;
    r.score_self  = ss;
    r.score_neigh = sn;
    exp_q.push_back(r);
    exp_id++;
  endtask

  task automatic check_result(input node_result_t exp);
    if (node_result_o.node_id !== exp.node_id) begin
      $display("Fail t=%0t node_result_o.node_id expected %0d got %0d",
               $time, exp.node_id, node_result_o.node_id);
      errors++;
    end
    for (int j = 0; j < NUM_FEAT_OUT; j++) begin
      if (node_result_o.wh[j] !== exp.wh[j]) begin
        $display("Fail t=%0t node_result_o.wh[%0d] expected %0d got %0d",
                 $time, j, exp.wh[j], node_result_o.wh[j]);
        errors++;
      end
    end
    if (node_result_o.score_self !== exp.score_self) begin
      $display("Fail t=%0t node_result_o.score_self expected %0d got %0d",
               $time, exp.score_self, node_result_o.score_self);
      errors++;
    end
    if (node_result_o.score_neigh !== exp.score_neigh) begin
      $display("Fail t=%0t node_result_o.score_neigh expected %0d got %0d",
               $time, exp.score_neigh, node_result_o.score_neigh);
      errors++;
    end
  endtask

  task automatic send_entries();
    int stall;
    stall = 0;
    while (ent_q.size() > 0 && stall < 1000) begin
      h_valid_i = 1'b1;
      h_entry_i = ent_q[0];
      #1;
      if (h_ready_o) begin
        void'(ent_q.pop_front());
        stall = 0;
      end else begin
        stall++;
      end
      @(posedge clk);
      #2;
    end
    h_valid_i = 1'b0;
    if (ent_q.size() > 0) begin
      $display("Timeout at %0t with H entries never accepted", $time);
      errors++;
      ent_q.delete();
    end
  endtask

  // Holds node_ready_i low for the first hold cycles
  task automatic collect_results(input int n, input int hold);
    int           got;
    int           cyc;
    logic         have_prev;
    node_result_t prev;
    got = 0;
    cyc = 0;
    have_prev = 1'b0;
    while (got < n && cyc < 2000) begin
      node_ready_i = (cyc >= hold);
      #1;
      if (node_valid_o) begin
        if (have_prev && node_result_o !== prev) begin
          $display("Fail t=%0t node_result_o expected %h got %h", $time, prev, node_result_o);
          errors++;
        end
        if (!node_ready_i) begin
          hold_seen++;
          if (h_ready_o !== 1'b0) begin
            $display("Fail t=%0t h_ready_o expected 0 got %b", $time, h_ready_o);
            errors++;
          end
          prev = node_result_o;
          have_prev = 1'b1;
        end else begin
          check_result(exp_q.pop_front());
          got++;
          have_prev = 1'b0;
        end
      end
      @(posedge clk);
      #2;
      cyc++;
    end
    node_ready_i = 1'b1;
    if (got < n) begin
      $display("Timeout at %0t with %0d of %0d node results received", $time, got, n);
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic reset_test();
    if (node_valid_o !== 1'b0) begin
      $display("Fail t=%0t node_valid_o expected 0 got %b", $time, node_valid_o);
      errors++;
    end
    if (h_ready_o !== 1'b1) begin
      $display("Fail t=%0t h_ready_o expected 1 got %b", $time, h_ready_o);
      errors++;
    end
    readback_all();
  endtask

  task automatic apb_test();
    load_weights();
    readback_all();
    apb_check(1'b1, 12'h200, 32'h5a, 1'b1);
    apb_check(1'b0, 12'h200, 32'h0, 1'b1);
    apb_check(1'b1, 12'hffc, 32'h5a, 1'b1);
    apb_check(1'b1, 12'h120, 32'h5a, 1'b1);
    apb_check(1'b0, 12'h120, 32'h0, 1'b1);
    apb_check(1'b1, 12'h001, 32'h5a, 1'b1);
    apb_check(1'b0, 12'h002, 32'h0, 1'b1);
    apb_check(1'b1, 12'h103, 32'h5a, 1'b1);
    readback_all();
  endtask

  task automatic single_row_test();
    int lat;
    build_row();
    send_entries();
    // Count edges after the one that took the last entry
    lat = 0;
    #1;
    while (!node_valid_o && lat < 20) begin
      @(posedge clk);
      #3;
      lat++;
    end
    if (!node_valid_o) begin
      $display("Timeout at %0t waiting for node_valid_o", $time);
      errors++;
      exp_q.delete();
    end else begin
      if (lat != 4) begin
        $display("Fail t=%0t latency expected 4 got %0d", $time, lat);
        errors++;
      end
      check_result(exp_q.pop_front());
    end
    @(posedge clk);
    #2;
  endtask

  task automatic stream_test(input int rows, input int hold);
    load_weights();
    for (int i = 0; i < rows; i++) begin
      build_row();
    end
    fork
      send_entries();
      collect_results(rows, hold);
    join
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    paddr_i      = '0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    pwdata_i     = '0;
    h_valid_i    = 1'b0;
    h_entry_i    = '0;
    node_ready_i = 1'b1;
    errors       = 0;
    hold_seen    = 0;
    lfsr         = 32'h9d811a2d;
    exp_id       = '0;
    for (int r = 0; r < NUM_FEAT_IN; r++) begin
      for (int c = 0; c < NUM_FEAT_OUT; c++) begin
        w_ref[r][c] = 0;
      end
    end
    for (int i = 0; i < A_LEN; i++) begin
      a_ref[i] = 0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    reset_test();
    apb_test();
    single_row_test();
    stream_test(20, 0);
    hold_seen = 0;
    stream_test(6, 40);
    if (hold_seen == 0) begin
      $display("No node result was ever held during the back-pressure test");
      errors++;
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hdl/gat_pkg.sv
hdl/gat_cfg_apb.sv
hdl/spmm_row_feeder.sv
hdl/spmm_lane.sv
hdl/attn_score_unit.sv
hdl/gat_layer_top.sv
dv/gat_tb.sv

/* run_sim.sh */
#!/bin/bash
# Compile and run the GAT layer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module gat_tb -f flist.f -o gat_sim
./obj_dir/gat_sim | tee sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
  exit 1
fi
